//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic intclk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		intclk = 1'b0;
		forever #4 intclk = ~intclk; // 8 ns period.
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge intclk);
		#1 arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_correlator.sv
`default_nettype none

module tb_correlator;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_timeout = 20;
	localparam int rise_timeout = 8;
	localparam int byte_timeout = 6;
	localparam int fall_timeout = 4;

	typedef struct packed {
		corr_pkg::line_t inv_mask;
		corr_pkg::line_t edge_mask;
		logic [31:0] len;
		logic all_ones;
		logic inject;
	} entry_t;

	logic intclk;
	logic arst_n;
	corr_pkg::line_t line_in;
	corr_pkg::byte_t rx_byte;
	logic rx_valid;
	logic tx_done;
	corr_pkg::byte_t tx_byte;
	logic tx_active;

	entry_t entries [$];
	logic [15:0] lfsr_state = 16'd65;
	int byte_errors = 0;
	int count_errors = 0;
	int flag_errors = 0;
	int other_errors = 0;
	bit timed_out = 1'b0;

	// Reference model state.
	corr_pkg::line_t m_inv;
	corr_pkg::line_t m_edge;
	corr_pkg::line_t m_prev_inv;
	corr_pkg::line_t m_prev_s;
	bit m_counting;
	bit m_dumping;
	corr_pkg::count_t m_ones [corr_pkg::num_inputs];
	corr_pkg::count_t m_auto [corr_pkg::num_inputs];
	corr_pkg::count_t m_cross [corr_pkg::num_baselines];
	corr_pkg::byte_t exp_bytes [corr_pkg::pkt_bytes];
	corr_pkg::count_t exp_words [corr_pkg::pkt_words];

	tb_clock clk_gen (
		.intclk(intclk),
		.arst_n(arst_n)
	);

	correlator_top uut (
		.intclk(intclk),
		.arst_n(arst_n),
		.line_in(line_in),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.tx_done(tx_done),
		.tx_byte(tx_byte),
		.tx_active(tx_active)
	);

	always @(posedge intclk) begin : ref_model
		corr_pkg::line_t inv;
		corr_pkg::line_t s;
		int b;
		if (!arst_n) begin
			m_inv = '0;
			m_edge = '0;
			m_prev_inv = '0;
			m_prev_s = '0;
			m_counting = 1'b0;
			m_dumping = 1'b0;
		end else begin
			inv = line_in ^ m_inv;
			s = (m_edge & (inv ^ m_prev_inv)) | (~m_edge & inv);
			m_prev_inv = inv;
			if (m_counting) begin
				b = 0;
				for (int i = 0; i < corr_pkg::num_inputs; i++) begin
					if (s[i] && m_ones[i] != corr_pkg::count_max)
						m_ones[i]++;
					if (s[i] == m_prev_s[i] && m_auto[i] != corr_pkg::count_max)
						m_auto[i]++;
					for (int j = i + 1; j < corr_pkg::num_inputs; j++) begin
						if (s[i] == s[j] && m_cross[b] != corr_pkg::count_max)
							m_cross[b]++;
						b++;
					end
				end
			end
			m_prev_s = s;
			// Commands act from the next edge.
			if (rx_valid && rx_byte[7:4] == corr_pkg::op_invert)
				m_inv = rx_byte[3:0];
			if (rx_valid && rx_byte[7:4] == corr_pkg::op_edge)
				m_edge = rx_byte[3:0];
			if (rx_valid && rx_byte[7:4] == corr_pkg::op_integrate) begin
				if (rx_byte[0] && !m_counting && !m_dumping) begin
					m_counting = 1'b1;
					for (int i = 0; i < corr_pkg::num_inputs; i++) begin
						m_ones[i] = '0;
						m_auto[i] = '0;
					end
					for (int i = 0; i < corr_pkg::num_baselines; i++)
						m_cross[i] = '0;
				end else if (!rx_byte[0] && m_counting) begin
					m_counting = 1'b0;
					m_dumping = 1'b1;
				end
			end
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [3:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	function automatic corr_pkg::byte_t hex_ascii(input logic [3:0] v);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[v];
	endfunction

	function automatic logic [3:0] hex_value(input corr_pkg::byte_t c);
		if (c >= "A" && c <= "F")
			return c[3:0] + 4'd9;
		return c[3:0];
	endfunction

	function automatic string word_name(input int w);
		if (w < corr_pkg::num_inputs)
			return $sformatf("ones_count[%0d]", w);
		if (w < 2 * corr_pkg::num_inputs)
			return $sformatf("auto_count[%0d]", w - corr_pkg::num_inputs);
		return $sformatf("cross_count[%0d]", w - 2 * corr_pkg::num_inputs);
	endfunction

	task automatic check_byte(input string name, input corr_pkg::byte_t got,
			input corr_pkg::byte_t expected);
		if (got !== expected) begin
			$display("ERROR %0d ns: %s = 8'h%02h, expected 8'h%02h", $time, name, got, expected);
			byte_errors++;
		end
	endtask

	task automatic check_count(input string name, input corr_pkg::count_t got,
			input corr_pkg::count_t expected);
		if (got !== expected) begin
			$display("ERROR %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
			count_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("ERROR %0d ns: %s = %b, expected %b", $time, name, got, expected);
			flag_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		other_errors++;
		timed_out = 1'b1;
	endtask

	task automatic add_entry(input corr_pkg::line_t inv_mask, input corr_pkg::line_t edge_mask,
			input int len, input bit all_ones, input bit inject);
		entry_t e;
		e.inv_mask = inv_mask;
		e.edge_mask = edge_mask;
		e.len = len;
		e.all_ones = all_ones;
		e.inject = inject;
		entries.push_back(e);
	endtask

	task automatic next_cycle();
		@(posedge intclk);
		#1;
	endtask

	task automatic send_command(input corr_pkg::byte_t b);
		logic [3:0] v;
		draw_bits(4, v);
		line_in = v;
		rx_byte = b;
		rx_valid = 1'b1;
		next_cycle();
		rx_valid = 1'b0;
	endtask

	task automatic build_expected();
		for (int i = 0; i < corr_pkg::num_inputs; i++) begin
			exp_words[i] = m_ones[i];
			exp_words[corr_pkg::num_inputs + i] = m_auto[i];
		end
		for (int b = 0; b < corr_pkg::num_baselines; b++)
			exp_words[2 * corr_pkg::num_inputs + b] = m_cross[b];
		exp_bytes[0] = corr_pkg::pkt_sync;
		exp_bytes[1] = hex_ascii(4'(corr_pkg::num_inputs - 1));
		exp_bytes[2] = hex_ascii(4'(corr_pkg::count_width / 4));
		for (int w = 0; w < corr_pkg::pkt_words; w++)
			for (int c = 0; c < 4; c++)
				exp_bytes[3 + 4 * w + c] = hex_ascii(exp_words[w][15 - 4 * c -: 4]);
		exp_bytes[corr_pkg::pkt_bytes - 1] = corr_pkg::pkt_term;
	endtask

	task automatic collect_packet(input entry_t e);
		corr_pkg::count_t got;
		logic [3:0] gap;
		int t;
		got = '0;
		build_expected();
		t = 0;
		while (!tx_active && t < rise_timeout) begin
			next_cycle();
			t++;
		end
		if (!tx_active) begin
			report_timeout("tx_active did not rise after the stop command");
			return;
		end
		for (int n = 0; n < corr_pkg::pkt_bytes; n++) begin
			t = 0;
			while (!tx_active && t < byte_timeout) begin
				next_cycle();
				t++;
			end
			if (!tx_active) begin
				report_timeout($sformatf("packet ended after %0d bytes", n));
				return;
			end
			check_byte($sformatf("tx_byte (byte %0d)", n), tx_byte, exp_bytes[n]);
			if (n >= 3 && n < corr_pkg::pkt_bytes - 1) begin
				got = {got[11:0], hex_value(tx_byte)};
				if ((n - 3) % 4 == 3) begin
					check_count(word_name((n - 3) / 4), got, exp_words[(n - 3) / 4]);
					if (e.all_ones)
						check_count(word_name((n - 3) / 4), got, corr_pkg::count_max);
				end
			end
			if (e.inject && n == 20)
				send_command({corr_pkg::op_integrate, 4'h1}); // Must be ignored.
			draw_bits(2, gap);
			repeat (gap) next_cycle();
			tx_done = 1'b1;
			next_cycle();
			tx_done = 1'b0;
		end
		check_flag("tx_active", tx_active, 1'b0); // Exactly pkt_bytes long.
		t = 0;
		while (tx_active && t < fall_timeout) begin
			next_cycle();
			t++;
		end
		if (tx_active) begin
			report_timeout("tx_active did not fall after the last byte");
			return;
		end
		next_cycle();
		next_cycle();
		m_dumping = 1'b0;
	endtask

	task automatic run_entry(input entry_t e);
		logic [3:0] v;
		send_command({corr_pkg::op_invert, e.inv_mask});
		send_command({corr_pkg::op_edge, e.edge_mask});
		send_command({corr_pkg::op_integrate, 4'h1});
		for (int k = 1; k <= e.len; k++) begin
			if (e.all_ones) begin
				line_in = '1;
			end else begin
				draw_bits(4, v);
				line_in = v;
			end
			if (k == e.len) begin
				rx_byte = {corr_pkg::op_integrate, 4'h0};
				rx_valid = 1'b1;
			end
			check_flag("tx_active", tx_active, 1'b0);
			next_cycle();
		end
		rx_valid = 1'b0;
		collect_packet(e);
		if (e.inject && !timed_out) begin
			// A stray stop after an ignored start gives no packet.
			send_command({corr_pkg::op_integrate, 4'h0});
			for (int k = 0; k < 12; k++) begin
				check_flag("tx_active", tx_active, 1'b0);
				next_cycle();
			end
		end
	endtask

	initial begin : main
		logic [3:0] v;
		int t;
		line_in = '0;
		rx_byte = '0;
		rx_valid = 1'b0;
		tx_done = 1'b0;
		add_entry(4'h0, 4'h0, 40, 1'b0, 1'b0);
		add_entry(4'h5, 4'h0, 37, 1'b0, 1'b0);
		add_entry(4'h0, 4'h3, 25, 1'b0, 1'b0);
		add_entry(4'h8, 4'h9, 18, 1'b0, 1'b1);
		add_entry(4'h0, 4'h0, 70000, 1'b1, 1'b0); // Saturates everything.
		add_entry(4'h2, 4'hf, 12, 1'b0, 1'b0);
		t = 0;
		while (arst_n !== 1'b1 && t < reset_timeout) begin
			@(posedge intclk);
			t++;
		end
		#1;
		if (arst_n !== 1'b1)
			report_timeout("reset was never released");
		for (int k = 0; k < 10 && !timed_out; k++) begin
			draw_bits(4, v);
			line_in = v;
			check_flag("tx_active", tx_active, 1'b0);
			next_cycle();
		end
		for (int n = 0; n < entries.size() && !timed_out; n++)
			run_entry(entries[n]);
		$display("Errors: %0d byte, %0d count, %0d flag, %0d other",
			byte_errors, count_errors, flag_errors, other_errors);
		if (byte_errors + count_errors + flag_errors + other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
src/corr_pkg.sv
src/corr_control.sv
src/line_conditioner.sv
src/pulse_counter.sv
src/cross_correlator.sv
src/packet_serializer.sv
src/correlator_top.sv
sim/tb_clock.sv
sim/tb_correlator.sv

//--- src/corr_control.sv
`default_nettype none

module corr_control (
	input wire intclk,
	input wire arst_n,
	input wire corr_pkg::byte_t rx_byte,
	input wire rx_valid,
	input wire tx_active,
	output corr_pkg::line_t invert_mask,
	output corr_pkg::line_t edge_mask,
	output logic clear,
	output logic accumulate,
	output logic dump
);

	corr_pkg::ctrl_state_t state;
	logic [3:0] opcode;
	logic start_cmd;
	logic stop_cmd;
	logic dump_pend;
	logic active_d;

	assign opcode = rx_byte[7:4];
	assign start_cmd = rx_valid && opcode == corr_pkg::op_integrate && rx_byte[0];
	assign stop_cmd = rx_valid && opcode == corr_pkg::op_integrate && !rx_byte[0];

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= corr_pkg::ctl_idle;
			invert_mask <= '0;
			edge_mask <= '0;
			clear <= 1'b0;
			accumulate <= 1'b0;
			dump <= 1'b0;
			dump_pend <= 1'b0;
			active_d <= 1'b0;
		end else begin
			clear <= 1'b0;
			dump_pend <= 1'b0;
			dump <= dump_pend; // Lets the last count land first.
			active_d <= tx_active;

			// Masks are taken in any state.
			if (rx_valid && opcode == corr_pkg::op_invert)
				invert_mask <= rx_byte[corr_pkg::num_inputs-1:0];
			if (rx_valid && opcode == corr_pkg::op_edge)
				edge_mask <= rx_byte[corr_pkg::num_inputs-1:0];

			case (state)
				corr_pkg::ctl_idle: begin
					if (start_cmd) begin
						state <= corr_pkg::ctl_integrate;
						clear <= 1'b1;
						accumulate <= 1'b1;
					end
				end
				corr_pkg::ctl_integrate: begin
					if (stop_cmd) begin
						state <= corr_pkg::ctl_dump;
						accumulate <= 1'b0;
						dump_pend <= 1'b1;
					end
				end
				corr_pkg::ctl_dump: begin
					if (active_d && !tx_active) // Packet finished.
						state <= corr_pkg::ctl_idle;
				end
				default: state <= corr_pkg::ctl_idle;
			endcase
		end
	end

	a_dump_outside_window: assert property (@(posedge intclk) disable iff (!arst_n)
		!(dump && accumulate));

endmodule

`default_nettype wire

//--- src/corr_pkg.sv
`default_nettype none

package corr_pkg;

	localparam int num_inputs = 4;
	localparam int num_baselines = num_inputs * (num_inputs - 1) / 2;
	localparam int count_width = 16;

	typedef logic [num_inputs-1:0] line_t;
	typedef logic [count_width-1:0] count_t;
	typedef logic [7:0] byte_t;

	localparam count_t count_max = '1;

	// Baseline pairs in packet order.
	localparam int bl_first [num_baselines] = '{0, 0, 0, 1, 1, 2};
	localparam int bl_second [num_baselines] = '{1, 2, 3, 2, 3, 3};

	// Command opcodes, upper nibble of the byte.
	localparam logic [3:0] op_invert = 4'h1;
	localparam logic [3:0] op_edge = 4'h2;
	localparam logic [3:0] op_integrate = 4'h3;

	localparam byte_t pkt_sync = 8'h53; // 'S'
	localparam byte_t pkt_term = 8'h0d; // CR
	localparam int pkt_words = 2 * num_inputs + num_baselines;
	localparam int pkt_chars = count_width / 4;
	localparam int pkt_bytes = 3 + pkt_chars * pkt_words + 1;
	localparam int pkt_idx_width = $clog2(pkt_bytes);

	typedef logic [pkt_idx_width-1:0] pkt_idx_t;

	typedef enum logic [1:0] {
		ctl_idle,
		ctl_integrate,
		ctl_dump
	} ctrl_state_t;

	// Add one unless already at full scale.
	function automatic count_t sat_inc(input count_t c, input logic hit);
		if (hit && c != count_max)
			return c + 1'b1;
		return c;
	endfunction

	// Uppercase ASCII hex digit.
	function automatic byte_t hex_char(input logic [3:0] v);
		if (v < 4'd10)
			return 8'h30 + v;
		return 8'h37 + v;
	endfunction

endpackage

`default_nettype wire

//--- src/correlator_top.sv
`default_nettype none

module correlator_top (
	input wire intclk,
	input wire arst_n,
	input wire corr_pkg::line_t line_in,
	input wire corr_pkg::byte_t rx_byte,
	input wire rx_valid,
	input wire tx_done,
	output corr_pkg::byte_t tx_byte,
	output logic tx_active
);

	corr_pkg::line_t invert_mask;
	corr_pkg::line_t edge_mask;
	corr_pkg::line_t sample;
	logic clear;
	logic accumulate;
	logic dump;
	corr_pkg::count_t ones_count [corr_pkg::num_inputs];
	corr_pkg::count_t auto_count [corr_pkg::num_inputs];
	corr_pkg::count_t cross_count [corr_pkg::num_baselines];

	corr_control u_control (
		.intclk(intclk),
		.arst_n(arst_n),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.tx_active(tx_active),
		.invert_mask(invert_mask),
		.edge_mask(edge_mask),
		.clear(clear),
		.accumulate(accumulate),
		.dump(dump)
	);

	line_conditioner u_conditioner (
		.intclk(intclk),
		.arst_n(arst_n),
		.line_in(line_in),
		.invert_mask(invert_mask),
		.edge_mask(edge_mask),
		.sample(sample)
	);

	pulse_counter u_pulse (
		.intclk(intclk),
		.arst_n(arst_n),
		.sample(sample),
		.clear(clear),
		.accumulate(accumulate),
		.ones_count(ones_count),
		.auto_count(auto_count)
	);

	cross_correlator u_cross (
		.intclk(intclk),
		.arst_n(arst_n),
		.sample(sample),
		.clear(clear),
		.accumulate(accumulate),
		.cross_count(cross_count)
	);

	packet_serializer u_serializer (
		.intclk(intclk),
		.arst_n(arst_n),
		.dump(dump),
		.tx_done(tx_done),
		.ones_count(ones_count),
		.auto_count(auto_count),
		.cross_count(cross_count),
		.tx_byte(tx_byte),
		.tx_active(tx_active)
	);

endmodule

`default_nettype wire

//--- src/cross_correlator.sv
`default_nettype none

module cross_correlator (
	input wire intclk,
	input wire arst_n,
	input wire corr_pkg::line_t sample,
	input wire clear,
	input wire accumulate,
	output corr_pkg::count_t cross_count [corr_pkg::num_baselines]
);

	logic acc_d;
	logic [corr_pkg::num_baselines-1:0] agree;

	for (genvar b = 0; b < corr_pkg::num_baselines; b++) begin : g_pair
		assign agree[b] = sample[corr_pkg::bl_first[b]] == sample[corr_pkg::bl_second[b]];
	end

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			acc_d <= 1'b0;
			for (int b = 0; b < corr_pkg::num_baselines; b++)
				cross_count[b] <= '0;
		end else begin
			acc_d <= accumulate;
			for (int b = 0; b < corr_pkg::num_baselines; b++) begin
				if (clear)
					cross_count[b] <= '0;
				else if (acc_d)
					cross_count[b] <= corr_pkg::sat_inc(cross_count[b], agree[b]);
			end
		end
	end

	// A saturated count must hold, never wrap.
	for (genvar b = 0; b < corr_pkg::num_baselines; b++) begin : g_chk
		a_no_wrap: assert property (@(posedge intclk) disable iff (!arst_n)
			(cross_count[b] == corr_pkg::count_max && !clear) |=> cross_count[b] != '0);
	end

endmodule

`default_nettype wire

//--- src/line_conditioner.sv
`default_nettype none

module line_conditioner (
	input wire intclk,
	input wire arst_n,
	input wire corr_pkg::line_t line_in,
	input wire corr_pkg::line_t invert_mask,
	input wire corr_pkg::line_t edge_mask,
	output corr_pkg::line_t sample
);

	corr_pkg::line_t inv;
	corr_pkg::line_t prev;
	corr_pkg::line_t change;

	assign inv = line_in ^ invert_mask;
	assign change = inv ^ prev; // High where the line toggled.

	// History keeps running outside the window too.
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			prev <= '0;
			sample <= '0;
		end else begin
			prev <= inv;
			sample <= (change & edge_mask) | (inv & ~edge_mask);
		end
	end

endmodule

`default_nettype wire

//--- src/packet_serializer.sv
`default_nettype none

module packet_serializer (
	input wire intclk,
	input wire arst_n,
	input wire dump,
	input wire tx_done,
	input wire corr_pkg::count_t ones_count [corr_pkg::num_inputs],
	input wire corr_pkg::count_t auto_count [corr_pkg::num_inputs],
	input wire corr_pkg::count_t cross_count [corr_pkg::num_baselines],
	output corr_pkg::byte_t tx_byte,
	output logic tx_active
);

	localparam corr_pkg::pkt_idx_t last_idx = corr_pkg::pkt_idx_t'(corr_pkg::pkt_bytes - 1);
	localparam corr_pkg::pkt_idx_t hdr_len = corr_pkg::pkt_idx_t'(3);

	corr_pkg::count_t snap [corr_pkg::pkt_words];
	corr_pkg::pkt_idx_t idx;
	corr_pkg::pkt_idx_t pos;
	corr_pkg::count_t word;
	logic [1:0] nib;

	// Ones, then auto, then cross.
	always_ff @(posedge intclk) begin
		if (dump) begin
			for (int i = 0; i < corr_pkg::num_inputs; i++) begin
				snap[i] <= ones_count[i];
				snap[corr_pkg::num_inputs + i] <= auto_count[i];
			end
			for (int b = 0; b < corr_pkg::num_baselines; b++)
				snap[2 * corr_pkg::num_inputs + b] <= cross_count[b];
		end
	end

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			idx <= '0;
			tx_active <= 1'b0;
		end else if (dump) begin
			idx <= '0;
			tx_active <= 1'b1;
		end else if (tx_active && tx_done) begin
			if (idx == last_idx) begin
				idx <= '0;
				tx_active <= 1'b0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Payload position: word in the upper bits, character below.
	assign pos = idx - hdr_len;
	assign word = snap[pos[corr_pkg::pkt_idx_width-1:2]];
	assign nib = 2'd3 - pos[1:0]; // MS nibble first.

	always_comb begin
		if (idx == '0)
			tx_byte = corr_pkg::pkt_sync;
		else if (idx == corr_pkg::pkt_idx_t'(1))
			tx_byte = corr_pkg::hex_char(4'(corr_pkg::num_inputs - 1));
		else if (idx == corr_pkg::pkt_idx_t'(2))
			tx_byte = corr_pkg::hex_char(4'(corr_pkg::pkt_chars));
		else if (idx == last_idx)
			tx_byte = corr_pkg::pkt_term;
		else
			tx_byte = corr_pkg::hex_char(word[{nib, 2'b00} +: 4]);
	end

	a_idx_range: assert property (@(posedge intclk) disable iff (!arst_n)
		idx < corr_pkg::pkt_idx_t'(corr_pkg::pkt_bytes));

endmodule

`default_nettype wire

//--- src/pulse_counter.sv
`default_nettype none

module pulse_counter (
	input wire intclk,
	input wire arst_n,
	input wire corr_pkg::line_t sample,
	input wire clear,
	input wire accumulate,
	output corr_pkg::count_t ones_count [corr_pkg::num_inputs],
	output corr_pkg::count_t auto_count [corr_pkg::num_inputs]
);

	corr_pkg::line_t prev;
	logic acc_d;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			prev <= '0;
			acc_d <= 1'b0;
			for (int i = 0; i < corr_pkg::num_inputs; i++) begin
				ones_count[i] <= '0;
				auto_count[i] <= '0;
			end
		end else begin
			prev <= sample; // Lag-1 history.
			acc_d <= accumulate; // Aligns with the conditioner stage.
			for (int i = 0; i < corr_pkg::num_inputs; i++) begin
				if (clear) begin
					ones_count[i] <= '0;
					auto_count[i] <= '0;
				end else if (acc_d) begin
					ones_count[i] <= corr_pkg::sat_inc(ones_count[i], sample[i]);
					auto_count[i] <= corr_pkg::sat_inc(auto_count[i], sample[i] == prev[i]);
				end
			end
		end
	end

	for (genvar i = 0; i < corr_pkg::num_inputs; i++) begin : g_chk
		a_ones_mono: assert property (@(posedge intclk) disable iff (!arst_n)
			!clear |=> ones_count[i] >= $past(ones_count[i]));
		a_auto_mono: assert property (@(posedge intclk) disable iff (!arst_n)
			!clear |=> auto_count[i] >= $past(auto_count[i]));
	end

endmodule

`default_nettype wire
